// ==== logic/capture_pkg.sv ====
`default_nettype none

package capture_pkg;

    localparam int SAMPLE_W    = 16;
    localparam int TDATA_W     = 128;
    localparam int LINE_W      = 32;
    localparam int FRAME_LEN_W = 16;
    localparam int CH_ID_W     = 8;

    localparam int LANES = TDATA_W / SAMPLE_W; // samples per beat.

    localparam logic [7:0] HEADER_ID = 8'hA5; // tag in line 0 of each header.

    typedef logic [SAMPLE_W-1:0]    sample_t;
    typedef logic [TDATA_W-1:0]     tdata_t;
    typedef logic [TDATA_W/8-1:0]   tkeep_t;
    typedef logic [LINE_W-1:0]      line_t;
    typedef logic [FRAME_LEN_W-1:0] frame_len_t;
    typedef logic [CH_ID_W-1:0]     ch_id_t;

endpackage

`default_nettype wire

// ==== logic/sync_fifo.sv ====
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             ACLK,
    input  logic             ARESET,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             full,
    output logic             empty,
    output logic             overflow
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [PTR_W:0]   COUNT_FULL = (PTR_W + 1)'(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == COUNT_FULL);
    assign empty = (count == '0);
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    assign rd_data = mem[rd_ptr]; // head word is visible before the read.

    always_ff @(posedge ACLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
            if (wr_en && full) begin
                overflow <= 1'b1; // sticky.
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/sample_packer.sv ====
`default_nettype none

module sample_packer
    import capture_pkg::*;
(
    input  logic    ACLK,
    input  logic    ARESET,
    input  logic    sample_valid,
    input  sample_t sample_data,
    output logic    word_valid,
    output tdata_t  word_data
);

    localparam int LANE_W = $clog2(LANES);
    localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(LANES - 1);

    logic [LANE_W-1:0] lane_q;
    tdata_t            shift_q;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            lane_q     <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            if (sample_valid) begin
                if (lane_q == LAST_LANE) begin
                    lane_q     <= '0;
                    word_valid <= 1'b1; // word complete.
                end else begin
                    lane_q <= lane_q + 1'b1;
                end
            end
        end
    end

    // new samples enter at the top, so the oldest ends up in lane 0
    always_ff @(posedge ACLK) begin
        if (sample_valid) begin
            shift_q <= {sample_data, shift_q[TDATA_W-1:SAMPLE_W]};
        end
    end

    assign word_data = shift_q;

endmodule

`default_nettype wire

// ==== logic/capture_sequencer.sv ====
`default_nettype none

module capture_sequencer
    import capture_pkg::*;
#(
    parameter int HEADER_LINES = 4,
    parameter int FOOTER_LINES = 1
) (
    input  logic                                        ACLK,
    input  logic                                        ARESET,
    input  logic                                        capture_start,
    input  frame_len_t                                  capture_len,
    input  ch_id_t                                      capture_ch,
    input  logic                                        word_valid,
    input  tdata_t                                      word_data,
    output logic                                        data_wr_en,
    output tdata_t                                      data_wr_data,
    output logic                                        desc_wr_en,
    output logic [(HEADER_LINES+FOOTER_LINES)*LINE_W-1:0] desc_wr_data,
    output logic                                        capture_busy
);

    localparam int DESC_W = (HEADER_LINES + FOOTER_LINES) * LINE_W;

    typedef enum logic [1:0] {S_IDLE, S_CAPTURE, S_EMIT} state_t;

    state_t     state_q;
    frame_len_t len_q;
    frame_len_t cnt_q;
    ch_id_t     ch_q;
    line_t      seq_q;
    line_t      word_idx_q;
    line_t      start_idx_q;
    line_t      csum_q;
    logic       take;
    logic       accept;

    function automatic line_t fold_lanes(input tdata_t w);
        line_t acc;
        acc = '0;
        for (int i = 0; i < TDATA_W / LINE_W; i++) begin
            acc ^= w[i*LINE_W +: LINE_W];
        end
        return acc;
    endfunction

    assign take   = word_valid && (state_q == S_CAPTURE);
    assign accept = capture_start && (state_q != S_CAPTURE); // ignored while busy.

    assign data_wr_en   = take;
    assign data_wr_data = word_data;
    assign desc_wr_en   = (state_q == S_EMIT);
    assign capture_busy = (state_q == S_CAPTURE);

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            state_q    <= S_IDLE;
            cnt_q      <= '0;
            seq_q      <= '0;
            word_idx_q <= '0;
        end else begin
            if (word_valid) begin
                word_idx_q <= word_idx_q + 1'b1; // global word count.
            end
            if (state_q == S_EMIT) begin
                seq_q <= seq_q + 1'b1;
            end
            case (state_q)
                S_CAPTURE: begin
                    if (take) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cnt_q + 1'b1 == len_q) begin
                            state_q <= S_EMIT;
                        end
                    end
                end
                default: begin
                    state_q <= accept ? S_CAPTURE : S_IDLE;
                    cnt_q   <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (accept) begin
            len_q  <= capture_len;
            ch_q   <= capture_ch;
            csum_q <= '0;
        end else if (take) begin
            csum_q <= csum_q ^ fold_lanes(word_data);
        end
        if (take && cnt_q == '0) begin
            start_idx_q <= word_idx_q;
        end
    end

    // line 0 sits in the top bits
    always_comb begin
        desc_wr_data = '0;
        desc_wr_data[DESC_W-1 -: LINE_W] = {HEADER_ID, ch_q, len_q};
        desc_wr_data[DESC_W-1-LINE_W -: LINE_W] = seq_q;
        if (HEADER_LINES > 2) begin
            desc_wr_data[DESC_W-1-2*LINE_W -: LINE_W] = start_idx_q;
        end
        desc_wr_data[FOOTER_LINES*LINE_W-1 -: LINE_W] = csum_q; // footer line 0.
    end

endmodule

`default_nettype wire

// ==== logic/dataframe_gen.sv ====
`default_nettype none

module dataframe_gen
    import capture_pkg::*;
#(
    parameter int HEADER_LINES = 4,
    parameter int FOOTER_LINES = 1
) (
    input  logic                                        ACLK,
    input  logic                                        ARESET,
    input  logic                                        hf_fifo_empty,
    input  logic [(HEADER_LINES+FOOTER_LINES)*LINE_W-1:0] hf_fifo_dout,
    output logic                                        hf_fifo_rd_en,
    input  logic                                        adc_fifo_empty,
    input  tdata_t                                      adc_fifo_dout,
    output logic                                        adc_fifo_rd_en,
    input  logic                                        m_axis_tready,
    output logic                                        m_axis_tvalid,
    output tdata_t                                      m_axis_tdata,
    output tkeep_t                                      m_axis_tkeep,
    output logic                                        m_axis_tlast,
    output logic                                        frame_error
);

    localparam int DESC_W    = (HEADER_LINES + FOOTER_LINES) * LINE_W;
    localparam int HDR_BEATS = HEADER_LINES / 2;
    localparam int HALF_W    = TDATA_W / 2;
    localparam int KEEP_W    = $bits(tkeep_t);
    localparam int CNT_W     = FRAME_LEN_W + 1;

    localparam logic [CNT_W-1:0] CNT_IDLE = '1;
    localparam logic [CNT_W-1:0] HDR_CNT  = CNT_W'(HDR_BEATS);

    typedef logic [DESC_W-1:0] desc_t;

    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] nxt_cnt;
    logic [CNT_W-1:0] last_idx;
    frame_len_t       len_q;
    desc_t            desc_q;
    tdata_t           adc_delay_q;
    tdata_t           tdata_q;
    tdata_t           footer_beat;
    tkeep_t           tkeep_last;
    line_t            hf_line0;
    logic             tvalid_q;
    logic             pending_q;
    logic             error_q;
    logic             err_set;
    logic             clr;
    logic             idle;
    logic             tlast;
    logic             pre_last;
    logic             xfer;
    logic             start;
    logic             load_data;

    function automatic line_t desc_line(input desc_t desc, input int idx);
        return desc[DESC_W-1-idx*LINE_W -: LINE_W];
    endfunction

    // each line sits in the low bits of its half beat
    function automatic tdata_t pair_beat(input line_t hi, input line_t lo);
        return {{(HALF_W-LINE_W){1'b0}}, hi, {(HALF_W-LINE_W){1'b0}}, lo};
    endfunction

    function automatic tdata_t header_beat(input desc_t desc, input int beat);
        return pair_beat(desc_line(desc, 2*beat + 1), desc_line(desc, 2*beat));
    endfunction

    if (FOOTER_LINES == 1) begin : g_half_footer
        assign footer_beat = {{HALF_W{1'b1}}, {(HALF_W-LINE_W){1'b0}},
                              desc_line(desc_q, HEADER_LINES)};
        assign tkeep_last  = {{(KEEP_W/2){1'b0}}, {(KEEP_W/2){1'b1}}};
    end else begin : g_full_footer
        assign footer_beat = pair_beat(desc_line(desc_q, HEADER_LINES + 1),
                                       desc_line(desc_q, HEADER_LINES));
        assign tkeep_last  = '1;
    end

    assign hf_line0 = desc_line(hf_fifo_dout, 0);

    assign nxt_cnt  = cnt_q + 1'b1;
    assign last_idx = CNT_W'(len_q) + HDR_CNT; // footer beat index.
    assign idle     = (cnt_q == CNT_IDLE);
    assign tlast    = (cnt_q == last_idx);
    assign pre_last = (cnt_q == last_idx - 1'b1);
    assign xfer     = tvalid_q & m_axis_tready;

    // a new frame starts from idle, or right after the footer if one was seen
    assign start     = (idle & ~hf_fifo_empty & ~error_q) | (xfer & tlast & pending_q);
    assign load_data = xfer && (nxt_cnt >= HDR_CNT) && (nxt_cnt < last_idx);

    assign hf_fifo_rd_en  = start;
    assign adc_fifo_rd_en = start | (load_data & (nxt_cnt + 1'b1 < last_idx)); // prefetch.

    // descriptor waiting or a word needed, but no data left
    assign err_set = adc_fifo_empty & (~hf_fifo_empty | adc_fifo_rd_en);
    assign clr     = ARESET | error_q | err_set;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            error_q <= 1'b0;
        end else if (err_set) begin
            error_q <= 1'b1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (clr) begin
            cnt_q     <= CNT_IDLE;
            len_q     <= '0;
            tvalid_q  <= 1'b0;
            pending_q <= 1'b0;
        end else begin
            if (start) begin
                cnt_q    <= '0;
                len_q    <= hf_line0[FRAME_LEN_W-1:0];
                tvalid_q <= 1'b1;
            end else if (xfer) begin
                if (tlast) begin
                    cnt_q    <= CNT_IDLE;
                    tvalid_q <= 1'b0;
                end else begin
                    cnt_q <= nxt_cnt;
                end
            end
            if (pre_last) begin
                pending_q <= ~hf_fifo_empty; // next descriptor already there.
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (start) begin
            desc_q <= hf_fifo_dout;
        end
        if (adc_fifo_rd_en) begin
            adc_delay_q <= adc_fifo_dout;
        end
        if (start) begin
            tdata_q <= header_beat(hf_fifo_dout, 0);
        end else if (xfer && !tlast) begin
            if (nxt_cnt < HDR_CNT) begin
                tdata_q <= header_beat(desc_q, int'(nxt_cnt));
            end else if (load_data) begin
                tdata_q <= adc_delay_q;
            end else begin
                tdata_q <= footer_beat;
            end
        end
    end

    assign m_axis_tvalid = tvalid_q;
    assign m_axis_tdata  = tdata_q;
    assign m_axis_tlast  = tlast;
    assign m_axis_tkeep  = tlast ? tkeep_last : '1;
    assign frame_error   = error_q;

endmodule

`default_nettype wire

// ==== logic/adc_frame_top.sv ====
`default_nettype none

module adc_frame_top
    import capture_pkg::*;
#(
    parameter int HEADER_LINES = 4,
    parameter int FOOTER_LINES = 1,
    parameter int DATA_DEPTH   = 64,
    parameter int DESC_DEPTH   = 8
) (
    input  logic       ACLK,
    input  logic       ARESET,
    input  logic       sample_valid,
    input  sample_t    sample_data,
    input  logic       capture_start,
    input  frame_len_t capture_len,
    input  ch_id_t     capture_ch,
    input  logic       m_axis_tready,
    output logic       m_axis_tvalid,
    output tdata_t     m_axis_tdata,
    output tkeep_t     m_axis_tkeep,
    output logic       m_axis_tlast,
    output logic       capture_busy,
    output logic       frame_error
);

    localparam int DESC_W = (HEADER_LINES + FOOTER_LINES) * LINE_W;

    logic              word_valid;
    tdata_t            word_data;
    logic              data_wr_en;
    tdata_t            data_wr_data;
    logic              desc_wr_en;
    logic [DESC_W-1:0] desc_wr_data;
    logic              adc_rd_en;
    tdata_t            adc_dout;
    logic              adc_empty;
    logic              hf_rd_en;
    logic [DESC_W-1:0] hf_dout;
    logic              hf_empty;

    sample_packer i_packer (
        .ACLK         (ACLK),
        .ARESET       (ARESET),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .word_valid   (word_valid),
        .word_data    (word_data)
    );

    capture_sequencer #(
        .HEADER_LINES (HEADER_LINES),
        .FOOTER_LINES (FOOTER_LINES)
    ) i_sequencer (
        .ACLK          (ACLK),
        .ARESET        (ARESET),
        .capture_start (capture_start),
        .capture_len   (capture_len),
        .capture_ch    (capture_ch),
        .word_valid    (word_valid),
        .word_data     (word_data),
        .data_wr_en    (data_wr_en),
        .data_wr_data  (data_wr_data),
        .desc_wr_en    (desc_wr_en),
        .desc_wr_data  (desc_wr_data),
        .capture_busy  (capture_busy)
    );

    sync_fifo #(
        .WIDTH (TDATA_W),
        .DEPTH (DATA_DEPTH)
    ) i_data_fifo (
        .ACLK     (ACLK),
        .ARESET   (ARESET),
        .wr_en    (data_wr_en),
        .wr_data  (data_wr_data),
        .rd_en    (adc_rd_en),
        .rd_data  (adc_dout),
        .full     (),
        .empty    (adc_empty),
        .overflow ()
    );

    sync_fifo #(
        .WIDTH (DESC_W),
        .DEPTH (DESC_DEPTH)
    ) i_desc_fifo (
        .ACLK     (ACLK),
        .ARESET   (ARESET),
        .wr_en    (desc_wr_en),
        .wr_data  (desc_wr_data),
        .rd_en    (hf_rd_en),
        .rd_data  (hf_dout),
        .full     (),
        .empty    (hf_empty),
        .overflow ()
    );

    dataframe_gen #(
        .HEADER_LINES (HEADER_LINES),
        .FOOTER_LINES (FOOTER_LINES)
    ) i_gen (
        .ACLK           (ACLK),
        .ARESET         (ARESET),
        .hf_fifo_empty  (hf_empty),
        .hf_fifo_dout   (hf_dout),
        .hf_fifo_rd_en  (hf_rd_en),
        .adc_fifo_empty (adc_empty),
        .adc_fifo_dout  (adc_dout),
        .adc_fifo_rd_en (adc_rd_en),
        .m_axis_tready  (m_axis_tready),
        .m_axis_tvalid  (m_axis_tvalid),
        .m_axis_tdata   (m_axis_tdata),
        .m_axis_tkeep   (m_axis_tkeep),
        .m_axis_tlast   (m_axis_tlast),
        .frame_error    (frame_error)
    );

endmodule

`default_nettype wire

// ==== sim/frame_checker.sv ====
`default_nettype none

module frame_checker
    import capture_pkg::*;
#(
    parameter int HEADER_LINES = 4,
    parameter int FOOTER_LINES = 1
) (
    input  logic       ACLK,
    input  logic       ARESET,
    input  logic       sample_valid,
    input  sample_t    sample_data,
    input  logic       capture_start,
    input  frame_len_t capture_len,
    input  ch_id_t     capture_ch,
    input  logic       m_axis_tready,
    input  logic       m_axis_tvalid,
    input  tdata_t     m_axis_tdata,
    input  tkeep_t     m_axis_tkeep,
    input  logic       m_axis_tlast,
    input  logic       frame_error,
    output int         check_errors,
    output int         frames_done,
    output int         starts_accepted
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORD_MEM  = 4096;
    localparam int HDR_BEATS = HEADER_LINES / 2;
    localparam int KEEP_W    = TDATA_W / 8;

    typedef logic [KEEP_W+TDATA_W:0] beat_t; // {tlast, tkeep, tdata}.

    tdata_t word_mem [WORD_MEM];
    tdata_t shift;
    tdata_t word_hold;
    logic   word_pend;
    int     lane;
    logic   capturing;
    int     cap_len;
    int     cap_cnt;
    ch_id_t cap_ch;
    line_t  cap_start;
    line_t  word_idx;
    line_t  seq;
    int     q_len [$];
    ch_id_t q_ch [$];
    line_t  q_seq [$];
    line_t  q_start [$];
    int     cur_len;
    ch_id_t cur_ch;
    line_t  cur_seq;
    line_t  cur_start;
    int     beat_idx;
    logic   prev_stall;
    tdata_t held_data;
    tkeep_t held_keep;
    logic   held_last;
    beat_t  exp_beat;
    int     n_errors = 0;
    int     n_frames = 0;
    int     n_starts = 0;

    assign check_errors    = n_errors;
    assign frames_done     = n_frames;
    assign starts_accepted = n_starts;

    function automatic line_t header_line(input int n, input ch_id_t ch, input int len,
                                          input line_t sq, input line_t st);
        case (n)
            0:       return {HEADER_ID, ch, frame_len_t'(len)};
            1:       return sq;
            2:       return st;
            default: return '0;
        endcase
    endfunction

    // header pairs first, then the frame words, then the footer
    function automatic beat_t ref_beat(input int idx, input ch_id_t ch, input int len,
                                       input line_t sq, input line_t st);
        tdata_t data;
        tkeep_t keep;
        logic   last;
        line_t  csum;
        int     i;
        int     k;
        keep = '1;
        last = 1'b0;
        csum = '0;
        if (idx < HDR_BEATS) begin
            data = {32'h0, header_line(2*idx + 1, ch, len, sq, st),
                    32'h0, header_line(2*idx, ch, len, sq, st)};
        end else if (idx < HDR_BEATS + len) begin
            data = word_mem[(st + idx - HDR_BEATS) % WORD_MEM];
        end else begin
            for (i = 0; i < len; i++) begin
                for (k = 0; k < TDATA_W / LINE_W; k++) begin
                    csum ^= word_mem[(st + i) % WORD_MEM][k*LINE_W +: LINE_W];
                end
            end
            last = 1'b1;
            if (FOOTER_LINES == 1) begin
                data = {{64{1'b1}}, 32'h0, csum};
                keep = {{(KEEP_W/2){1'b0}}, {(KEEP_W/2){1'b1}}}; // low half only.
            end else begin
                data = {96'h0, csum};
            end
        end
        return {last, keep, data};
    endfunction

    task automatic compare_value(input string name, input tdata_t expected, input tdata_t actual);
        if (actual !== expected) begin
            n_errors++;
            $display("CHECK FAILED %s frame %0d beat %0d: expected %0h, actual %0h",
                     name, n_frames, beat_idx, expected, actual);
        end
    endtask

    task automatic clear_model();
        lane       = 0;
        word_pend  = 1'b0;
        capturing  = 1'b0;
        cap_cnt    = 0;
        word_idx   = '0;
        seq        = '0;
        beat_idx   = 0;
        prev_stall = 1'b0;
        q_len.delete();
        q_ch.delete();
        q_seq.delete();
        q_start.delete();
    endtask

    // packer and sequencer as seen at the coming rising edge
    task automatic model_step();
        logic busy_before;
        busy_before = capturing;
        if (busy_before && word_pend) begin
            if (cap_cnt == 0) begin
                cap_start = word_idx;
            end
            cap_cnt++;
            if (cap_cnt == cap_len) begin
                q_len.push_back(cap_len);
                q_ch.push_back(cap_ch);
                q_seq.push_back(seq);
                q_start.push_back(cap_start);
                seq++;
                capturing = 1'b0;
            end
        end
        if (word_pend) begin
            word_mem[word_idx % WORD_MEM] = word_hold;
            word_idx++;
        end
        if (capture_start && !busy_before) begin
            capturing = 1'b1;
            cap_len   = int'(capture_len);
            cap_ch    = capture_ch;
            cap_cnt   = 0;
            n_starts++;
        end
        word_pend = 1'b0;
        if (sample_valid) begin
            shift = {sample_data, shift[TDATA_W-1:SAMPLE_W]};
            if (lane == LANES - 1) begin
                lane      = 0;
                word_pend = 1'b1;
                word_hold = shift;
            end else begin
                lane++;
            end
        end
    endtask

    task automatic check_beat();
        if (prev_stall && !frame_error) begin
            if (m_axis_tvalid !== 1'b1) begin
                n_errors++;
                $display("m_axis_tvalid dropped while the beat was stalled");
            end
            compare_value("m_axis_tdata (held)", held_data, m_axis_tdata);
            compare_value("m_axis_tkeep (held)", held_keep, m_axis_tkeep);
            compare_value("m_axis_tlast (held)", held_last, m_axis_tlast);
        end
        if (frame_error && m_axis_tvalid) begin
            n_errors++;
            $display("m_axis_tvalid is high while frame_error is set");
        end
        if (m_axis_tvalid && beat_idx == 0 && q_len.size() == 0) begin
            n_errors++;
            $display("output beat appeared with no pending frame");
        end else if (m_axis_tvalid && m_axis_tready) begin
            if (beat_idx == 0) begin
                cur_len   = q_len.pop_front();
                cur_ch    = q_ch.pop_front();
                cur_seq   = q_seq.pop_front();
                cur_start = q_start.pop_front();
            end
            exp_beat = ref_beat(beat_idx, cur_ch, cur_len, cur_seq, cur_start);
            compare_value("m_axis_tdata", exp_beat[TDATA_W-1:0], m_axis_tdata);
            compare_value("m_axis_tkeep", exp_beat[TDATA_W +: KEEP_W], m_axis_tkeep);
            compare_value("m_axis_tlast", exp_beat[TDATA_W+KEEP_W], m_axis_tlast);
            if (m_axis_tlast) begin
                n_frames++;
                beat_idx = 0;
            end else begin
                beat_idx++;
            end
        end
        prev_stall = m_axis_tvalid && !m_axis_tready;
        held_data  = m_axis_tdata;
        held_keep  = m_axis_tkeep;
        held_last  = m_axis_tlast;
    endtask

    // falling edge sees what the DUT registers on the next rising edge
    always @(negedge ACLK) begin
        if (ARESET) begin
            clear_model();
        end else begin
            model_step();
            check_beat();
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_adc_frame.sv ====
`default_nettype none

module tb_adc_frame
    import capture_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HEADER_LINES    = 4;
    localparam int FOOTER_LINES    = 1;
    localparam int CAPTURE_TIMEOUT = 2000;
    localparam int FRAME_TIMEOUT   = 4000;

    logic       ACLK = 1'b0;
    logic       ARESET;
    logic       sample_valid;
    sample_t    sample_data;
    logic       capture_start;
    frame_len_t capture_len;
    ch_id_t     capture_ch;
    logic       m_axis_tready;
    logic       m_axis_tvalid;
    tdata_t     m_axis_tdata;
    tkeep_t     m_axis_tkeep;
    logic       m_axis_tlast;
    logic       capture_busy;
    logic       frame_error;

    int     check_errors;
    int     frames_done;
    int     starts_accepted;
    int     bench_errors    = 0;
    int     frames_expected = 0;
    integer seed            = 53;
    integer rnd_gap;
    integer rnd_data;
    integer rnd_ready;
    logic   stream_on;
    logic   gap_mode;
    int     ready_mode; // 0 low, 1 high, 2 random.
    logic   on_now;
    logic   gap_now;
    int     ready_now;

    always #10 ACLK = ~ACLK;

    adc_frame_top #(
        .HEADER_LINES (HEADER_LINES),
        .FOOTER_LINES (FOOTER_LINES)
    ) i_dut (
        .ACLK          (ACLK),
        .ARESET        (ARESET),
        .sample_valid  (sample_valid),
        .sample_data   (sample_data),
        .capture_start (capture_start),
        .capture_len   (capture_len),
        .capture_ch    (capture_ch),
        .m_axis_tready (m_axis_tready),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tlast  (m_axis_tlast),
        .capture_busy  (capture_busy),
        .frame_error   (frame_error)
    );

    frame_checker #(
        .HEADER_LINES (HEADER_LINES),
        .FOOTER_LINES (FOOTER_LINES)
    ) i_checker (
        .ACLK            (ACLK),
        .ARESET          (ARESET),
        .sample_valid    (sample_valid),
        .sample_data     (sample_data),
        .capture_start   (capture_start),
        .capture_len     (capture_len),
        .capture_ch      (capture_ch),
        .m_axis_tready   (m_axis_tready),
        .m_axis_tvalid   (m_axis_tvalid),
        .m_axis_tdata    (m_axis_tdata),
        .m_axis_tkeep    (m_axis_tkeep),
        .m_axis_tlast    (m_axis_tlast),
        .frame_error     (frame_error),
        .check_errors    (check_errors),
        .frames_done     (frames_done),
        .starts_accepted (starts_accepted)
    );

    // sample stream and TREADY, one random draw order per cycle
    always @(posedge ACLK) begin
        on_now    = stream_on;
        gap_now   = gap_mode;
        ready_now = ready_mode;
        #2;
        rnd_gap       = $random(seed);
        rnd_data      = $random(seed);
        rnd_ready     = $random(seed);
        sample_valid  = on_now && (!gap_now || rnd_gap[1:0] != 2'b00);
        sample_data   = rnd_data[SAMPLE_W-1:0];
        m_axis_tready = (ready_now == 1) || (ready_now == 2 && rnd_ready[0]);
    end

    task automatic reset_dut();
        ARESET = 1'b1;
        repeat (3) @(posedge ACLK);
        #2;
        ARESET = 1'b0;
    endtask

    task automatic pause(input int cycles);
        repeat (cycles) begin
            @(posedge ACLK);
            #2;
        end
    endtask

    task automatic pulse_start(input int len, input ch_id_t ch);
        capture_len   = frame_len_t'(len);
        capture_ch    = ch;
        capture_start = 1'b1;
        @(posedge ACLK);
        #2;
        capture_start = 1'b0;
    endtask

    task automatic await_capture_end();
        int cycles;
        cycles = 0;
        while (capture_busy === 1'b1 && cycles < CAPTURE_TIMEOUT) begin
            @(posedge ACLK);
            #2;
            cycles++;
        end
        if (capture_busy === 1'b1) begin
            bench_errors++;
            $display("timeout: capture_busy never fell after a frame start");
        end
    endtask

    task automatic run_frame(input int len, input ch_id_t ch);
        pulse_start(len, ch);
        frames_expected++;
        await_capture_end();
    endtask

    task automatic wait_frames(input int count);
        int cycles;
        cycles = 0;
        while (frames_done < count && cycles < FRAME_TIMEOUT) begin
            @(posedge ACLK);
            #2;
            cycles++;
        end
        if (frames_done < count) begin
            bench_errors++;
            $display("timeout: only %0d of %0d frames arrived", frames_done, count);
        end
        if (frame_error) begin
            bench_errors++;
            $display("frame_error is set during normal traffic");
        end
    endtask

    task automatic expect_frame_error();
        int cycles;
        cycles = 0;
        while (frame_error !== 1'b1 && cycles < FRAME_TIMEOUT) begin
            @(posedge ACLK);
            #2;
            cycles++;
        end
        if (frame_error !== 1'b1) begin
            bench_errors++;
            $display("timeout: frame_error did not rise after the data FIFO overflowed");
        end
    endtask

    initial begin
        ARESET        = 1'b1;
        sample_valid  = 1'b0;
        sample_data   = '0;
        capture_start = 1'b0;
        capture_len   = '0;
        capture_ch    = '0;
        m_axis_tready = 1'b0;
        stream_on     = 1'b0;
        gap_mode      = 1'b0;
        ready_mode    = 0;
        reset_dut();
        stream_on = 1'b1;
        pause(20); // no frame pending yet.

        ready_mode = 1;
        run_frame(5, 8'h11);
        wait_frames(frames_expected);

        run_frame(3, 8'h22);
        run_frame(7, 8'h33);
        pulse_start(6, 8'h44);
        frames_expected++;
        if (capture_busy !== 1'b1) begin
            bench_errors++;
            $display("capture_busy is low where a start should be ignored");
        end
        pulse_start(9, 8'h55); // lands while busy.
        await_capture_end();
        run_frame(1, 8'h56);
        run_frame(12, 8'h57);
        wait_frames(frames_expected);

        ready_mode = 2;
        run_frame(10, 8'h60);
        run_frame(4, 8'h61);
        run_frame(16, 8'h62);
        wait_frames(frames_expected);

        ready_mode = 1;
        gap_mode   = 1'b1;
        pause(30);
        run_frame(8, 8'h63);
        pause(40);
        run_frame(2, 8'h64);
        wait_frames(frames_expected);
        if (starts_accepted != frames_done) begin
            bench_errors++;
            $display("%0d starts accepted but %0d frames emitted", starts_accepted, frames_done);
        end

        // overflow of the data FIFO
        gap_mode   = 1'b0;
        ready_mode = 0;
        pulse_start(80, 8'h66);
        await_capture_end();
        ready_mode = 1;
        expect_frame_error();
        pause(20);
        reset_dut();
        if (frame_error !== 1'b0 || m_axis_tvalid !== 1'b0) begin
            bench_errors++;
            $display("frame_error or m_axis_tvalid still set after ARESET");
        end
        run_frame(5, 8'h77);
        wait_frames(frames_expected);
        if (frames_done != frames_expected) begin
            bench_errors++;
            $display("%0d frames emitted where %0d were started", frames_done, frames_expected);
        end

        $display("frames checked %0d, checker errors %0d, testbench errors %0d",
                 frames_done, check_errors, bench_errors);
        if (check_errors == 0 && bench_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/capture_pkg.sv
logic/sync_fifo.sv
logic/sample_packer.sv
logic/capture_sequencer.sv
logic/dataframe_gen.sv
logic/adc_frame_top.sv
sim/frame_checker.sv
sim/tb_adc_frame.sv
